// File: src/ascon_ctrl_pkg.sv
// constants, phase encoding and packed control structs
// shared by the ascon sequencing controller blocks
package ascon_ctrl_pkg;

    // ==============================
    // lane and slicing
    // ==============================
    localparam int LANE_BITS = 64;     // one state lane
    localparam int SHARES    = 3;      // masking order + 1
    localparam int PAR       = 22;     // bits per share per cycle

    // masked rounds move PAR bits per cycle, plus one cycle for the register stage
    localparam int MASK_SLICES   = (LANE_BITS + PAR - 1) / PAR + 1;
    // unmasked rounds move PAR*SHARES bits per cycle
    localparam int NOMASK_SLICES = (LANE_BITS + PAR*SHARES - 1) / (PAR*SHARES);
    localparam int SLICE_CNT_W   = $clog2(MASK_SLICES + 1);

    // ==============================
    // blocks and rounds
    // ==============================
    localparam int BLOCK_BYTES        = 16;
    localparam int VBYTES_W           = $clog2(BLOCK_BYTES) + 1;  // 0..16
    localparam int ROUNDS             = 12;
    localparam int NOMASK_FIRST_ROUND = 4;                        // p8 runs 4..11
    localparam int ROUND_CNT_W        = $clog2(ROUNDS);

    typedef enum logic [4:0] {
        IDLE, INIT_LOAD,
        INIT_SHIFT, INIT_SHIFT_LAST, INIT_DIFFUSE, INIT_DIFFUSE_LAST,
        ABSORB_AD,
        AD_SHIFT, AD_SHIFT_LAST, AD_DIFFUSE, AD_DIFFUSE_LAST,
        ABSORB_MSG,
        MSG_SHIFT, MSG_SHIFT_LAST, MSG_DIFFUSE, MSG_DIFFUSE_LAST,
        FIN_SHIFT, FIN_SHIFT_LAST, FIN_DIFFUSE,
        SQUEEZE_TAG, DONE
    } phase_t;

    typedef struct packed {
        logic                valid;
        logic                last_block;   // closes associated data
        logic                eot;          // closes the message
        logic [VBYTES_W-1:0] valid_bytes;
    } data_in_t;

    typedef struct packed {
        logic shift_en;
        logic shift_type;        // 1: PAR-bit masked shift
        logic last_cycle;
        logic write_en;
        logic sel_init_load;
        logic sel_diff_x3;
        logic sel_diff_x4;
        logic sel_masked_round;
        logic sel_padding;
        logic sel_xor_key;
        logic sel_absorb_data;
    } path_ctrl_t;

    typedef struct packed {
        logic last_load;
        logic last_value;
        logic extra_load;
        logic extra_value;
    } flag_ctrl_t;

endpackage

// File: src/ascon_shift_counter.sv
// slice counter for serial state shifting
// wraps at the masked or unmasked slice limit
`timescale 1ns/10ps

module ascon_shift_counter (
    input  logic clk,
    input  logic reset_n,
    input  logic shift_en,
    input  logic masked,
    output logic slice_last
);
    import ascon_ctrl_pkg::*;

    logic [SLICE_CNT_W-1:0] slice_cnt;
    logic [SLICE_CNT_W-1:0] slice_limit;

    // masked rounds walk PAR-bit slices, unmasked ones whole shares
    assign slice_limit = masked ? SLICE_CNT_W'(MASK_SLICES) : SLICE_CNT_W'(NOMASK_SLICES);
    assign slice_last  = (slice_cnt == slice_limit);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slice_cnt <= '0;
        end else if (shift_en) begin
            if (slice_last)
                slice_cnt <= '0;                   // ready for the next round
            else
                slice_cnt <= slice_cnt + 1'b1;
        end
    end

endmodule

// File: src/ascon_round_counter.sv
// permutation round counter
// p12 runs 0..11, p8 runs 4..11, restart chosen by masked
`timescale 1ns/10ps

module ascon_round_counter (
    input  logic clk,
    input  logic reset_n,
    input  logic round_en,      // one pulse per diffuse cycle
    input  logic round_clear,   // finalization restart
    input  logic masked,
    output logic round_last
);
    import ascon_ctrl_pkg::*;

    logic [ROUND_CNT_W-1:0] round_cnt;
    logic [ROUND_CNT_W-1:0] restart_val;

    assign round_last  = (round_cnt == ROUND_CNT_W'(ROUNDS - 1));
    assign restart_val = masked ? '0 : ROUND_CNT_W'(NOMASK_FIRST_ROUND);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            round_cnt <= '0;
        end else if (round_clear) begin
            round_cnt <= '0;                       // clear wins over advance
        end else if (round_en) begin
            if (round_last)
                round_cnt <= restart_val;          // start of the next permutation
            else
                round_cnt <= round_cnt + 1'b1;
        end
    end

endmodule

// File: src/ascon_block_tracker.sv
// last-block and extra-padding flags
// plus the partial-block compare on valid_bytes
`timescale 1ns/10ps

module ascon_block_tracker (
    input  logic                                clk,
    input  logic                                reset_n,
    input  ascon_ctrl_pkg::flag_ctrl_t          flags,
    input  logic [ascon_ctrl_pkg::VBYTES_W-1:0] valid_bytes,
    output logic                                last_done,
    output logic                                extra_pending,
    output logic                                partial
);
    import ascon_ctrl_pkg::*;

    // short block gets padded in place
    assign partial = (valid_bytes < VBYTES_W'(BLOCK_BYTES));

    // ==============================
    // flags, loaded on fsm command
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_done     <= 1'b0;
            extra_pending <= 1'b0;
        end else begin
            if (flags.last_load)
                last_done <= flags.last_value;     // last ad block absorbed
            if (flags.extra_load)
                extra_pending <= flags.extra_value; // a padding-only block still owed
        end
    end

endmodule

// File: src/ascon_phase_fsm.sv
// phase register of the controller, next-phase logic
// and mealy decode of datapath, counter and handshake controls
`timescale 1ns/10ps

module ascon_phase_fsm (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      start,
    input  logic                      key_valid,
    input  ascon_ctrl_pkg::data_in_t  data_in,
    input  logic                      slice_last,     // from shift counter
    input  logic                      round_last,     // from round counter
    input  logic                      last_done,
    input  logic                      extra_pending,
    input  logic                      partial,
    output ascon_ctrl_pkg::path_ctrl_t path,
    output ascon_ctrl_pkg::flag_ctrl_t flags,
    output logic                      shift_en,       // slice counter enable
    output logic                      masked,
    output logic                      round_en,
    output logic                      round_clear,
    output logic                      key_load,
    output logic                      ready_for_data,
    output logic                      ciphertext_valid,
    output logic                      ready_tag,
    output logic                      done
);
    import ascon_ctrl_pkg::*;

    phase_t phase, next_phase;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) phase <= IDLE;
        else          phase <= next_phase;
    end

    assign masked = path.sel_masked_round;   // counters follow the datapath mode

    // ==============================
    // next phase
    // ==============================
    always_comb begin
        next_phase = phase;
        case (phase)
            IDLE:              if (start) next_phase = INIT_LOAD;
            INIT_LOAD:         if (key_valid) next_phase = INIT_SHIFT;
            INIT_SHIFT:        if (slice_last) next_phase = INIT_SHIFT_LAST;
            INIT_SHIFT_LAST:   next_phase = round_last ? INIT_DIFFUSE_LAST : INIT_DIFFUSE;
            INIT_DIFFUSE:      next_phase = INIT_SHIFT;
            INIT_DIFFUSE_LAST: next_phase = ABSORB_AD;
            ABSORB_AD:         if (extra_pending || data_in.valid) next_phase = AD_SHIFT;
            AD_SHIFT:          if (slice_last) next_phase = AD_SHIFT_LAST;
            AD_SHIFT_LAST:     next_phase = round_last ? AD_DIFFUSE_LAST : AD_DIFFUSE;
            AD_DIFFUSE:        next_phase = AD_SHIFT;
            AD_DIFFUSE_LAST: begin
                // all ad consumed, padding block included -> message
                if (last_done && !extra_pending) next_phase = ABSORB_MSG;
                else                             next_phase = ABSORB_AD;
            end
            ABSORB_MSG: begin
                if (extra_pending)
                    next_phase = FIN_SHIFT;            // padding block needs no permutation
                else if (data_in.valid)
                    next_phase = (data_in.eot && partial) ? FIN_SHIFT : MSG_SHIFT;
            end
            MSG_SHIFT:         if (slice_last) next_phase = MSG_SHIFT_LAST;
            MSG_SHIFT_LAST:    next_phase = round_last ? MSG_DIFFUSE_LAST : MSG_DIFFUSE;
            MSG_DIFFUSE:       next_phase = MSG_SHIFT;
            MSG_DIFFUSE_LAST:  next_phase = ABSORB_MSG;
            FIN_SHIFT:         if (slice_last) next_phase = FIN_SHIFT_LAST;
            FIN_SHIFT_LAST:    next_phase = FIN_DIFFUSE;
            FIN_DIFFUSE:       next_phase = round_last ? SQUEEZE_TAG : FIN_SHIFT;
            SQUEEZE_TAG:       next_phase = DONE;
            DONE:              if (!start) next_phase = IDLE;
            default:           next_phase = IDLE;
        endcase
    end

    // ==============================
    // output decode
    // ==============================
    always_comb begin
        path                  = '0;
        path.sel_masked_round = 1'b1;     // masked unless a phase says otherwise
        flags                 = '0;
        shift_en              = 1'b0;
        round_en              = 1'b0;
        round_clear           = 1'b0;
        key_load              = 1'b0;
        ready_for_data        = 1'b0;
        ciphertext_valid      = 1'b0;
        ready_tag             = 1'b0;
        done                  = 1'b0;
        case (phase)
            INIT_LOAD: begin
                path.sel_init_load = 1'b1;           // iv, key, nonce into state
                key_load           = key_valid;
                path.write_en      = key_valid;
            end
            INIT_SHIFT, FIN_SHIFT: begin
                path.shift_en   = 1'b1;
                path.shift_type = 1'b1;              // PAR bits per share
                shift_en        = 1'b1;
            end
            INIT_SHIFT_LAST, FIN_SHIFT_LAST: begin
                path.shift_en   = 1'b1;
                path.shift_type = 1'b1;
                path.last_cycle = 1'b1;
            end
            AD_SHIFT, MSG_SHIFT: begin
                path.sel_masked_round = 1'b0;
                path.shift_en         = 1'b1;        // full PAR*SHARES per cycle
                shift_en              = 1'b1;
            end
            AD_SHIFT_LAST, MSG_SHIFT_LAST: begin
                path.sel_masked_round = 1'b0;
                path.shift_en         = 1'b1;
                path.last_cycle       = 1'b1;
            end
            INIT_DIFFUSE: begin
                path.write_en = 1'b1;
                round_en      = 1'b1;
            end
            AD_DIFFUSE, MSG_DIFFUSE, MSG_DIFFUSE_LAST: begin
                path.sel_masked_round = 1'b0;
                path.write_en         = 1'b1;
                round_en              = 1'b1;
            end
            INIT_DIFFUSE_LAST: begin
                path.sel_masked_round = 1'b0;        // counter restarts at p8 start
                path.write_en         = 1'b1;
                path.sel_diff_x3      = 1'b1;        // x3,x4 ^= key
                path.sel_diff_x4      = 1'b1;
                path.sel_xor_key      = 1'b1;
                round_en              = 1'b1;
            end
            AD_DIFFUSE_LAST: begin
                path.sel_masked_round = 1'b0;
                path.write_en         = 1'b1;
                round_en              = 1'b1;
                if (last_done && !extra_pending) begin
                    path.sel_diff_x4 = 1'b1;         // domain separation bit
                    flags.last_load  = 1'b1;         // rearm for the message
                end
            end
            ABSORB_AD: begin
                path.sel_masked_round = 1'b0;
                if (extra_pending) begin
                    path.write_en        = 1'b1;
                    path.sel_absorb_data = 1'b1;
                    path.sel_padding     = 1'b1;     // padding-only block
                    flags.extra_load     = 1'b1;     // clears the pending flag
                end else if (data_in.valid) begin
                    path.write_en        = 1'b1;
                    path.sel_absorb_data = 1'b1;
                    if (data_in.last_block) begin
                        flags.last_load  = 1'b1;
                        flags.last_value = 1'b1;
                        if (partial) begin
                            path.sel_padding = 1'b1;
                        end else begin
                            flags.extra_load  = 1'b1;
                            flags.extra_value = 1'b1;
                        end
                    end
                end else begin
                    ready_for_data = 1'b1;
                end
            end
            ABSORB_MSG: begin
                path.sel_masked_round = 1'b0;
                if (extra_pending) begin
                    path.write_en        = 1'b1;
                    path.sel_absorb_data = 1'b1;
                    path.sel_padding     = 1'b1;
                    path.sel_init_load   = 1'b1;     // key mixed in before finalization
                    flags.extra_load     = 1'b1;
                    round_clear          = 1'b1;
                end else if (data_in.valid) begin
                    path.write_en        = 1'b1;
                    path.sel_absorb_data = 1'b1;
                    ciphertext_valid     = 1'b1;     // one strobe per block taken
                    if (data_in.eot && partial) begin
                        path.sel_padding   = 1'b1;
                        path.sel_init_load = 1'b1;
                        round_clear        = 1'b1;
                    end else if (data_in.eot) begin
                        flags.extra_load  = 1'b1;    // full last block, pad next
                        flags.extra_value = 1'b1;
                    end
                end else begin
                    ready_for_data = 1'b1;
                end
            end
            FIN_DIFFUSE: begin
                path.write_en = 1'b1;
                round_en      = 1'b1;
                if (round_last) begin
                    path.sel_diff_x3 = 1'b1;         // final key xor gives the tag
                    path.sel_diff_x4 = 1'b1;
                    path.sel_xor_key = 1'b1;
                    ready_tag        = 1'b1;
                end
            end
            DONE:    done = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: src/ascon_ctrl_top.sv
// top level of the ascon sequencing controller
// joins phase fsm, shift counter, round counter and block tracker
`timescale 1ns/10ps

module ascon_ctrl_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start,
    input  logic                       key_valid,
    input  ascon_ctrl_pkg::data_in_t   data_in,
    output ascon_ctrl_pkg::path_ctrl_t path,
    output logic                       key_load,
    output logic                       ready_for_data,
    output logic                       ciphertext_valid,
    output logic                       ready_tag,
    output logic                       done
);
    import ascon_ctrl_pkg::*;

    flag_ctrl_t flags;               // fsm -> tracker
    logic       shift_en;
    logic       masked;
    logic       round_en;
    logic       round_clear;
    logic       slice_last;          // counters -> fsm
    logic       round_last;
    logic       last_done;           // tracker -> fsm
    logic       extra_pending;
    logic       partial;

    ascon_phase_fsm u_fsm (
        .clk              (clk),
        .reset_n          (reset_n),
        .start            (start),
        .key_valid        (key_valid),
        .data_in          (data_in),
        .slice_last       (slice_last),
        .round_last       (round_last),
        .last_done        (last_done),
        .extra_pending    (extra_pending),
        .partial          (partial),
        .path             (path),
        .flags            (flags),
        .shift_en         (shift_en),
        .masked           (masked),
        .round_en         (round_en),
        .round_clear      (round_clear),
        .key_load         (key_load),
        .ready_for_data   (ready_for_data),
        .ciphertext_valid (ciphertext_valid),
        .ready_tag        (ready_tag),
        .done             (done)
    );

    ascon_shift_counter u_shift_cnt (
        .clk        (clk),
        .reset_n    (reset_n),
        .shift_en   (shift_en),
        .masked     (masked),
        .slice_last (slice_last)
    );

    ascon_round_counter u_round_cnt (
        .clk         (clk),
        .reset_n     (reset_n),
        .round_en    (round_en),
        .round_clear (round_clear),
        .masked      (masked),
        .round_last  (round_last)
    );

    ascon_block_tracker u_tracker (
        .clk           (clk),
        .reset_n       (reset_n),
        .flags         (flags),
        .valid_bytes   (data_in.valid_bytes),
        .last_done     (last_done),
        .extra_pending (extra_pending),
        .partial       (partial)
    );

endmodule

// File: bench/ascon_ctrl_checker.sv
// concurrent assertions on the controller outputs
// bound into ascon_ctrl_top
`timescale 1ns/10ps

module ascon_ctrl_checker (
    input logic                       clk,
    input logic                       reset_n,
    input ascon_ctrl_pkg::path_ctrl_t path,
    input logic                       ready_for_data,
    input logic                       ciphertext_valid,
    input logic                       ready_tag,
    input logic                       done
);

    // ready only while no block is offered, strobe only on a taken block
    a_ready_vs_ct: assert property (@(posedge clk) disable iff (!reset_n)
        !(ready_for_data && ciphertext_valid))
        else $error("ready_for_data and ciphertext_valid high in the same cycle");

    // tag strobe, squeeze, then done
    a_tag_then_done: assert property (@(posedge clk) disable iff (!reset_n)
        $past(ready_tag, 2) |-> (done || $past(done)))
        else $error("done did not follow ready_tag within 2 cycles");

    a_done_no_shift: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !path.shift_en)   // state is idle once done
        else $error("state shift enabled while done is high");

endmodule

bind ascon_ctrl_top ascon_ctrl_checker u_checker (
    .clk              (clk),
    .reset_n          (reset_n),
    .path             (path),
    .ready_for_data   (ready_for_data),
    .ciphertext_valid (ciphertext_valid),
    .ready_tag        (ready_tag),
    .done             (done)
);

// File: bench/tb_ascon_ctrl.sv
// directed testbench for the ascon sequencing controller
// clock, reset, run helpers, compare tasks and summary
`timescale 1ns/10ps

module tb_ascon_ctrl;
    import ascon_ctrl_pkg::*;

    localparam int TIMEOUT = 2000;             // cycles per wait

    typedef enum int {W_READY, W_TAKE, W_KEY, W_DONE, W_IDLE} wait_t;

    logic       clk       = 1'b0;
    logic       reset_n   = 1'b0;
    logic       start     = 1'b0;
    logic       key_valid = 1'b0;
    data_in_t   data_in   = '0;
    path_ctrl_t path;
    logic       key_load;
    logic       ready_for_data;
    logic       ciphertext_valid;
    logic       ready_tag;
    logic       done;

    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    integer seed         = 5;

    // monitor counters, written only by the monitor below
    int   cycle       = 0;
    int   key_cnt     = 0;
    int   stray_key   = 0;                     // key_load without key_valid
    int   ct_cnt      = 0;
    int   tag_cnt     = 0;
    int   pad_cnt     = 0;                     // padding-only absorbs
    int   pad_rdy_cnt = 0;
    int   tag_cycle   = 0;
    int   done_cycle  = 0;
    logic done_q      = 1'b0;

    ascon_ctrl_top dut0 (.*);

    always #4 clk = ~clk;

    // ==============================
    // monitor, samples at negedge
    // ==============================
    always @(negedge clk) begin
        cycle <= cycle + 1;
        if (reset_n) begin
            if (key_load) key_cnt <= key_cnt + 1;
            if (key_load && !key_valid) stray_key <= stray_key + 1;
            if (ciphertext_valid) ct_cnt <= ct_cnt + 1;
            if (ready_tag) begin
                tag_cnt   <= tag_cnt + 1;
                tag_cycle <= cycle;
            end
            if (path.sel_absorb_data && path.sel_padding && !data_in.valid) begin
                pad_cnt <= pad_cnt + 1;
                if (ready_for_data) pad_rdy_cnt <= pad_rdy_cnt + 1;
            end
            if (done && !done_q) done_cycle <= cycle;   // rising edge of done
            done_q <= done;
        end
    end

    function automatic logic watched(input wait_t w);
        case (w)
            W_READY: return ready_for_data;
            W_TAKE:  return path.sel_absorb_data && data_in.valid;
            W_KEY:   return key_load;
            W_DONE:  return done;
            default: return !done;
        endcase
    endfunction

    function automatic path_ctrl_t idle_path();
        path_ctrl_t p;
        p = '0;
        p.sel_masked_round = 1'b1;             // only control high when idle
        return p;
    endfunction

    task automatic wait_for(input wait_t w, input string test, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!watched(w) && n < TIMEOUT);
        if (!watched(w)) begin
            $display("%s: no %s within %0d cycles", test, what, TIMEOUT);
            errors++;
        end
    endtask

    // ==============================
    // compare tasks
    // ==============================
    task automatic compare_bit(input string test, input string what, input logic exp,
                               input logic act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %b actual %b", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string test, input string what, input int exp,
                                 input int act);
        if (act != exp) begin
            $display("FAIL %s: %s expected %0d actual %0d", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_path(input string test, input path_ctrl_t exp, input path_ctrl_t act);
        if (act !== exp) begin
            $display("FAIL %s: path expected %b actual %b", test, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("PASS %s", test);
        end else begin
            $display("FAIL %s: %0d checks failed", test, errors - err0);
            tests_failed++;
        end
    endtask

    // ==============================
    // run helpers
    // ==============================
    task automatic launch(input string test, input int key_delay);
        @(posedge clk);
        start <= 1'b1;
        repeat (key_delay) @(posedge clk);     // key arrives late
        key_valid <= 1'b1;
        wait_for(W_KEY, test, "key_load");
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    task automatic send_block(input string test, input logic is_msg, input logic last,
                              input int nbytes, input int gap);
        data_in_t blk;
        blk.valid       = 1'b1;
        blk.last_block  = last && !is_msg;
        blk.eot         = last && is_msg;
        blk.valid_bytes = VBYTES_W'(nbytes);
        wait_for(W_READY, test, "ready_for_data");
        repeat (gap) @(negedge clk);           // source not ready yet
        @(posedge clk);
        data_in <= blk;
        wait_for(W_TAKE, test, "block taken");
        compare_bit(test, "sel_padding", last && nbytes < BLOCK_BYTES, path.sel_padding);
        compare_bit(test, "ciphertext_valid", is_msg, ciphertext_valid);
        @(posedge clk);
        data_in <= '0;
    endtask

    task automatic finish_run(input string test, input int ct0, input int tag0,
                              input int exp_ct, input int hold);
        int low;
        low = 0;
        wait_for(W_DONE, test, "done");
        repeat (hold) begin
            @(negedge clk);
            if (!done) low++;
        end
        @(posedge clk);
        start <= 1'b0;
        compare_count(test, "ciphertext_valid pulses", exp_ct, ct_cnt - ct0);
        compare_count(test, "ready_tag pulses", 1, tag_cnt - tag0);
        compare_count(test, "cycles from ready_tag to done", 2, done_cycle - tag_cycle);
        if (hold > 0)
            compare_count(test, "cycles with done low while start held", 0, low);
        wait_for(W_IDLE, test, "fall of done");
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic test_reset();
        int err0;
        err0 = errors;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        compare_path("reset", idle_path(), path);
        compare_bit("reset", "key_load", 1'b0, key_load);
        compare_bit("reset", "ready_for_data", 1'b0, ready_for_data);
        compare_bit("reset", "ciphertext_valid", 1'b0, ciphertext_valid);
        compare_bit("reset", "ready_tag", 1'b0, ready_tag);
        compare_bit("reset", "done", 1'b0, done);
        report_test("reset", err0);
    endtask

    task automatic test_key_load();
        int err0, k0, s0, ct0, tag0;
        err0 = errors;
        k0   = key_cnt;
        s0   = stray_key;
        ct0  = ct_cnt;
        tag0 = tag_cnt;
        launch("key_load", 5);
        compare_count("key_load", "key_load pulses", 1, key_cnt - k0);
        compare_count("key_load", "key_load without key_valid", 0, stray_key - s0);
        send_block("key_load", 1'b0, 1'b1, 7, 0);
        send_block("key_load", 1'b1, 1'b1, 3, 0);
        finish_run("key_load", ct0, tag0, 1, 0);
        report_test("key_load", err0);
    endtask

    task automatic test_partial_run();
        int err0, ct0, tag0, nb_ad, nb_msg;
        err0   = errors;
        ct0    = ct_cnt;
        tag0   = tag_cnt;
        nb_ad  = 1 + ({$random(seed)} % 15);   // 1..15 bytes
        nb_msg = 1 + ({$random(seed)} % 15);
        launch("partial_last_blocks", 2);
        send_block("partial_last_blocks", 1'b0, 1'b0, BLOCK_BYTES, 0);
        send_block("partial_last_blocks", 1'b0, 1'b1, nb_ad, 3);
        send_block("partial_last_blocks", 1'b1, 1'b0, BLOCK_BYTES, 2);
        send_block("partial_last_blocks", 1'b1, 1'b0, BLOCK_BYTES, 0);
        send_block("partial_last_blocks", 1'b1, 1'b1, nb_msg, 4);
        finish_run("partial_last_blocks", ct0, tag0, 3, 0);
        report_test("partial_last_blocks", err0);
    endtask

    task automatic test_full_last();
        int err0, ct0, tag0, p0, pr0;
        err0 = errors;
        ct0  = ct_cnt;
        tag0 = tag_cnt;
        p0   = pad_cnt;
        pr0  = pad_rdy_cnt;
        launch("full_last_block", 3);
        send_block("full_last_block", 1'b0, 1'b1, 9, 1);
        send_block("full_last_block", 1'b1, 1'b1, BLOCK_BYTES, 2);
        finish_run("full_last_block", ct0, tag0, 1, 0);
        compare_count("full_last_block", "padding-only absorbs", 1, pad_cnt - p0);
        compare_count("full_last_block", "ready_for_data on padding", 0, pad_rdy_cnt - pr0);
        report_test("full_last_block", err0);
    endtask

    task automatic test_restart();
        int err0, ct0, tag0;
        err0 = errors;
        ct0  = ct_cnt;
        tag0 = tag_cnt;
        launch("return_to_idle", 1);
        send_block("return_to_idle", 1'b0, 1'b1, 4, 0);
        send_block("return_to_idle", 1'b1, 1'b1, 12, 0);
        finish_run("return_to_idle", ct0, tag0, 1, 10);   // start held 10 cycles
        compare_path("return_to_idle", idle_path(), path);
        ct0  = ct_cnt;
        tag0 = tag_cnt;
        launch("return_to_idle", 2);
        send_block("return_to_idle", 1'b0, 1'b1, 1, 2);
        send_block("return_to_idle", 1'b1, 1'b1, 15, 1);
        finish_run("return_to_idle", ct0, tag0, 1, 0);
        report_test("return_to_idle", err0);
    endtask

    initial begin
        test_reset();
        test_key_load();
        test_partial_run();
        test_full_last();
        test_restart();
        $display("tests run %0d, failed %0d, checks failed %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: src.f
src/ascon_ctrl_pkg.sv
src/ascon_shift_counter.sv
src/ascon_round_counter.sv
src/ascon_block_tracker.sv
src/ascon_phase_fsm.sv
src/ascon_ctrl_top.sv
bench/ascon_ctrl_checker.sv
bench/tb_ascon_ctrl.sv

// File: run.sh
#!/bin/sh
# compile and run the controller testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ascon_ctrl -f src.f -o tb_ascon_ctrl \
    && ./obj_dir/tb_ascon_ctrl > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
